// ==== eth_rx_mac.f ====
+incdir+include
hdl/eth_frame_pkg.sv
hdl/eth_stats_pkg.sv
hdl/crc32_checker.sv
hdl/rx_frame_fsm.sv
hdl/rx_stats_counters.sv
hdl/eth_rx_mac.sv
verif/rx_frame_checker.sv
verif/tb_eth_rx_mac.sv

// ==== hdl/crc32_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_config.svh"

module crc32_checker (
    input  wire logic       gmii_rx_clk,
    input  wire logic       switch_rst_n,
    input  wire logic       crc_init,    // level, reload the seed
    input  wire logic       crc_update,  // strobe, fold crc_data in
    input  wire logic [7:0] crc_data,
    output logic            crc_good     // residue match
);

    logic [31:0] crc_reg;

    // one byte through the reflected crc, lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0]  data);
        logic [31:0] crc;
        crc = crc_in ^ {24'h000000, data}; // byte enters at the low end
        for (int i = 0; i < 8; i++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ `ETH_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            crc_reg <= `ETH_CRC_INIT;
        end else if (crc_init) begin
            crc_reg <= `ETH_CRC_INIT;          // held through idle and preamble
        end else if (crc_update) begin
            crc_reg <= crc32_byte(crc_reg, crc_data);
        end
    end

    // fcs bytes are folded in too, so a clean frame lands on the residue
    assign crc_good = (crc_reg == `ETH_CRC_RESIDUE);

    // fsm only seeds outside the frame and only updates inside it
    a_init_update_excl: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        !(crc_init && crc_update))
        else $error("crc_init and crc_update high together");

endmodule

`default_nettype wire

// ==== hdl/eth_frame_pkg.sv ====
`default_nettype none

`include "eth_rx_config.svh"

package eth_frame_pkg;

    // receive fsm states
    typedef enum logic [2:0] {
        IDLE,     // waiting for the first preamble byte
        PREAMBLE, // counting 0x55, then the sfd
        HEADER,   // dst, src, ethertype
        PAYLOAD,  // data and fcs, cut through
        WAIT_IFG  // gap, inputs ignored
    } rx_state_t;

    // byte count of one frame, fcs included
    typedef logic [`ETH_LEN_WIDTH-1:0] frame_len_t;

endpackage

`default_nettype wire

// ==== hdl/eth_rx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_config.svh"

module eth_rx_mac import eth_frame_pkg::*, eth_stats_pkg::*; (
    input  wire logic       gmii_rx_clk,
    input  wire logic       switch_rst_n,
    input  wire logic [7:0] gmii_rx_data,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,

    // frame stream
    output logic [7:0]      frame_data,
    output logic            frame_valid,
    output logic            frame_sof,
    output logic            frame_eof,
    output logic            frame_error,
    output frame_len_t      frame_length,

    // status
    output stat_count_t     rx_frame_count,
    output stat_count_t     crc_error_count,
    output stat_count_t     rx_error_count,
    output stat_count_t     preamble_error_count
);

    logic        crc_init;
    logic        crc_update;
    logic [7:0]  crc_data;
    logic        crc_good;
    stat_event_t stat_event;

    rx_frame_fsm u_fsm (
        .gmii_rx_clk, .switch_rst_n, .gmii_rx_data, .gmii_rx_dv, .gmii_rx_er,
        .crc_good, .crc_init, .crc_update, .crc_data,
        .frame_data, .frame_valid, .frame_sof, .frame_eof, .frame_error,
        .frame_length, .stat_event
    );

    crc32_checker u_crc (
        .gmii_rx_clk, .switch_rst_n, .crc_init, .crc_update, .crc_data, .crc_good
    );

    rx_stats_counters u_stats (
        .gmii_rx_clk, .switch_rst_n, .stat_event,
        .rx_frame_count, .crc_error_count, .rx_error_count, .preamble_error_count
    );

endmodule

`default_nettype wire

// ==== hdl/eth_stats_pkg.sv ====
`default_nettype none

package eth_stats_pkg;

    localparam int STAT_COUNT_WIDTH = 32;

    // one code per finished frame or aborted preamble
    typedef enum logic [2:0] {
        EV_NONE,
        EV_PREAMBLE_ERR,  // er seen before the sfd
        EV_FRAME_OK,
        EV_FRAME_ERR,     // er, runt or oversize, but fcs good
        EV_FRAME_CRC_ERR  // bad residue, wins over EV_FRAME_ERR
    } stat_event_t;

    typedef logic [STAT_COUNT_WIDTH-1:0] stat_count_t;

endpackage

`default_nettype wire

// ==== hdl/rx_frame_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_config.svh"

module rx_frame_fsm import eth_frame_pkg::*, eth_stats_pkg::*; (
    input  wire logic       gmii_rx_clk,
    input  wire logic       switch_rst_n,
    input  wire logic [7:0] gmii_rx_data,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,
    input  wire logic       crc_good,

    // crc checker side
    output logic            crc_init,
    output logic            crc_update,
    output logic [7:0]      crc_data,

    // frame stream, all registered
    output logic [7:0]      frame_data,
    output logic            frame_valid,
    output logic            frame_sof,    // with the first valid byte
    output logic            frame_eof,    // one cycle after the last byte
    output logic            frame_error,  // only valid with eof
    output frame_len_t      frame_length, // only valid with eof
    output stat_event_t     stat_event
);

    localparam int PRE_CNT_W = $clog2(`ETH_PREAMBLE_LEN + 1);
    localparam int IFG_CNT_W = $clog2(`ETH_IFG_LEN);

    rx_state_t              state, next_state;
    logic [PRE_CNT_W-1:0]   pre_cnt, next_pre_cnt;  // preamble bytes seen
    logic [IFG_CNT_W-1:0]   ifg_cnt, next_ifg_cnt;
    frame_len_t             byte_count;             // accepted bytes, fcs included
    logic                   err_flag, next_err;     // sticky frame error
    stat_event_t            next_event;
    logic                   accept;                 // byte taken this cycle
    logic                   leave;                  // last cycle of the frame
    logic                   over_max;

    assign over_max = (byte_count > frame_len_t'(`ETH_MAX_FRAME));

    // ====================
    // next state
    // ====================
    always_comb begin
        next_state   = state;
        next_pre_cnt = pre_cnt;
        next_ifg_cnt = ifg_cnt;
        next_err     = err_flag;
        next_event   = EV_NONE;
        accept       = 1'b0;
        leave        = 1'b0;

        case (state)
            IDLE: begin
                next_err = 1'b0;
                if (gmii_rx_dv && !gmii_rx_er && gmii_rx_data == `ETH_PREAMBLE_BYTE) begin
                    next_pre_cnt = PRE_CNT_W'(1);
                    next_state   = PREAMBLE;
                end
            end

            PREAMBLE: begin
                if (gmii_rx_er) begin
                    next_state = IDLE;            // aborted, counted
                    next_event = EV_PREAMBLE_ERR;
                end else if (!gmii_rx_dv) begin
                    next_state = IDLE;            // carrier dropped, silent
                end else if (pre_cnt == PRE_CNT_W'(`ETH_PREAMBLE_LEN)) begin
                    // full preamble, sfd or nothing
                    next_state = (gmii_rx_data == `ETH_SFD_BYTE) ? HEADER : IDLE;
                end else if (gmii_rx_data == `ETH_PREAMBLE_BYTE) begin
                    next_pre_cnt = pre_cnt + 1'b1;
                end else begin
                    next_state = IDLE;            // stray byte
                end
            end

            HEADER, PAYLOAD: begin
                if (gmii_rx_dv && !gmii_rx_er && !over_max) begin
                    accept = 1'b1;
                    if (byte_count == frame_len_t'(`ETH_MAX_FRAME)) begin
                        next_err = 1'b1;          // this byte goes past max
                    end
                    if (state == HEADER &&
                        byte_count == frame_len_t'(`ETH_HEADER_BYTES - 1)) begin
                        next_state = PAYLOAD;
                    end
                end else begin
                    // first bad sample or one past max ends the frame
                    leave      = 1'b1;
                    next_state = WAIT_IFG;
                    if (gmii_rx_er || byte_count < frame_len_t'(`ETH_MIN_FRAME)) begin
                        next_err = 1'b1;
                    end
                    if (!crc_good) begin
                        next_event = EV_FRAME_CRC_ERR;
                    end else if (next_err) begin
                        next_event = EV_FRAME_ERR;
                    end else begin
                        next_event = EV_FRAME_OK;
                    end
                end
            end

            WAIT_IFG: begin
                if (ifg_cnt == IFG_CNT_W'(`ETH_IFG_LEN - 1)) begin
                    next_ifg_cnt = '0;
                    next_state   = IDLE;
                end else begin
                    next_ifg_cnt = ifg_cnt + 1'b1;
                end
            end

            default: next_state = IDLE;
        endcase
    end

    // crc seeded while no frame is open
    assign crc_init   = (state == IDLE) || (state == PREAMBLE);
    assign crc_update = accept;
    assign crc_data   = gmii_rx_data;

    // ====================
    // registers
    // ====================
    always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state        <= IDLE;
            pre_cnt      <= '0;
            ifg_cnt      <= '0;
            byte_count   <= '0;
            err_flag     <= 1'b0;
            frame_valid  <= 1'b0;
            frame_sof    <= 1'b0;
            frame_eof    <= 1'b0;
            frame_error  <= 1'b0;
            frame_length <= '0;
            stat_event   <= EV_NONE;
        end else begin
            state       <= next_state;
            pre_cnt     <= next_pre_cnt;
            ifg_cnt     <= next_ifg_cnt;
            err_flag    <= next_err;
            stat_event  <= next_event;   // pulses for one cycle
            frame_valid <= accept;
            frame_sof   <= accept && (byte_count == '0);
            frame_eof   <= leave;        // valid is already low then
            if (state == IDLE) begin
                byte_count <= '0;
            end else if (accept) begin
                byte_count <= byte_count + 1'b1;
            end
            if (leave) begin
                frame_error  <= next_err || !crc_good;
                frame_length <= byte_count;
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (accept) begin
            frame_data <= gmii_rx_data;  // one cycle behind the gmii sample
        end
    end

    // ====================
    // checks
    // ====================
    a_sof_valid: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        frame_sof |-> frame_valid)
        else $error("frame_sof without frame_valid");

    a_eof_not_valid: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        !(frame_eof && frame_valid))
        else $error("frame_eof overlaps frame_valid");

    a_state_legal: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        state inside {IDLE, PREAMBLE, HEADER, PAYLOAD, WAIT_IFG})
        else $error("illegal rx state %0d", state);

endmodule

`default_nettype wire

// ==== hdl/rx_stats_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_stats_counters import eth_stats_pkg::*; (
    input  wire logic        gmii_rx_clk,
    input  wire logic        switch_rst_n,
    input  wire stat_event_t stat_event,
    output stat_count_t      rx_frame_count,       // every finished frame
    output stat_count_t      crc_error_count,      // bad residue
    output stat_count_t      rx_error_count,       // any frame error
    output stat_count_t      preamble_error_count  // er before the sfd
);

    logic is_frame;
    logic is_error;
    logic is_crc;
    logic is_preamble;

    // event decode
    assign is_crc      = (stat_event == EV_FRAME_CRC_ERR);
    assign is_error    = is_crc || (stat_event == EV_FRAME_ERR);
    assign is_frame    = is_error || (stat_event == EV_FRAME_OK);
    assign is_preamble = (stat_event == EV_PREAMBLE_ERR); // no frame, nothing else

    always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            rx_frame_count       <= '0;
            crc_error_count      <= '0;
            rx_error_count       <= '0;
            preamble_error_count <= '0;
        end else begin
            if (is_frame) begin
                rx_frame_count <= rx_frame_count + 1'b1;
            end
            if (is_error) begin
                rx_error_count <= rx_error_count + 1'b1;
            end
            if (is_crc) begin
                crc_error_count <= crc_error_count + 1'b1;
            end
            if (is_preamble) begin
                preamble_error_count <= preamble_error_count + 1'b1;
            end
        end
    end

    // crc errors are a subset of errors, errors a subset of frames
    a_count_order: assert property (@(posedge gmii_rx_clk) disable iff (!switch_rst_n)
        (rx_frame_count >= rx_error_count) && (rx_error_count >= crc_error_count))
        else $error("status counters out of order");

endmodule

`default_nettype wire

// ==== include/eth_rx_config.svh ====
`ifndef ETH_RX_CONFIG_SVH
`define ETH_RX_CONFIG_SVH

// ====================
// gmii framing
// ====================
`define ETH_PREAMBLE_BYTE 8'h55        // repeated before the sfd
`define ETH_SFD_BYTE      8'hD5
`define ETH_PREAMBLE_LEN  7            // preamble bytes ahead of the sfd
`define ETH_HEADER_BYTES  14           // dst + src + ethertype

// frame size limits, fcs counted in
`define ETH_MIN_FRAME     64
`define ETH_MAX_FRAME     1518         // untagged
`define ETH_LEN_WIDTH     11           // covers max + 1

// ====================
// fcs check
// ====================
`define ETH_CRC_POLY      32'hEDB88320 // reflected 802.3 polynomial
`define ETH_CRC_INIT      32'hFFFFFFFF
`define ETH_CRC_RESIDUE   32'hDEBB20E3 // register after data + fcs, no final xor
`define ETH_IFG_LEN       12           // gap cycles before the next frame

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the eth_rx_mac testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f eth_rx_mac.f --top-module tb_eth_rx_mac -o tb_eth_rx_mac

./obj_dir/tb_eth_rx_mac | tee sim.log

# the pipe hides the simulator status, so the log decides
if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1

// ==== verif/rx_frame_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_checker import eth_frame_pkg::*; (
    input  wire logic        gmii_rx_clk,
    input  wire logic        switch_rst_n,
    input  wire logic [7:0]  frame_data,
    input  wire logic        frame_valid,
    input  wire logic        frame_sof,
    input  wire logic        frame_eof,
    input  wire logic        frame_error,
    input  wire frame_len_t  frame_length,
    input  wire logic [31:0] case_id,
    input  wire logic        expect_frame,  // case should give a frame
    input  wire logic [31:0] exp_count,     // valid bytes
    input  wire logic [31:0] exp_sum,       // sum of those bytes
    input  wire frame_len_t  exp_len,
    input  wire logic        exp_err,
    output logic [31:0]      frames_seen,
    output logic [31:0]      pass_count,
    output logic [31:0]      fail_count
);

    logic [31:0] byte_cnt;   // bytes of the open frame
    logic [31:0] byte_sum;
    logic        sof_bad;    // sof missing or misplaced in this frame

    function automatic logic same_value(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // outputs are registered, so the posedge sees last cycle's values
    always @(posedge gmii_rx_clk or negedge switch_rst_n) begin : watch
        logic ok;
        if (!switch_rst_n) begin
            byte_cnt    <= '0;
            byte_sum    <= '0;
            sof_bad     <= 1'b0;
            frames_seen <= '0;
            pass_count  <= '0;
            fail_count  <= '0;
        end else begin
            if (frame_valid) begin
                byte_cnt <= byte_cnt + 32'd1;
                byte_sum <= byte_sum + {24'h0, frame_data};
                if (frame_sof != (byte_cnt == 0)) begin  // sof only on byte 0
                    $display("mismatch at %0t: frame_sof expected %0d got %0d",
                             $time, byte_cnt == 0, frame_sof);
                    sof_bad <= 1'b1;
                end
            end
            if (frame_eof) begin
                ok = !sof_bad;
                ok = same_value("frame_valid count", exp_count, byte_cnt) && ok;
                ok = same_value("frame_data sum", exp_sum, byte_sum) && ok;
                ok = same_value("frame_length", 32'(exp_len), 32'(frame_length)) && ok;
                ok = same_value("frame_error", 32'(exp_err), 32'(frame_error)) && ok;
                if (!expect_frame) begin
                    $display("case %0d: the DUT put out a frame where none was expected",
                             case_id);
                    ok = 1'b0;
                end
                $display("case %0d: %s, length %0d, error %0d", case_id,
                         ok ? "pass" : "fail", frame_length, frame_error);
                if (ok) begin
                    pass_count <= pass_count + 32'd1;
                end else begin
                    fail_count <= fail_count + 32'd1;
                end
                frames_seen <= frames_seen + 32'd1;
                byte_cnt    <= '0;
                byte_sum    <= '0;
                sof_bad     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_eth_rx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_config.svh"

module tb_eth_rx_mac import eth_frame_pkg::*, eth_stats_pkg::*; ();

    localparam int NUM_CASES    = 10;
    localparam int GAP_CYCLES   = `ETH_IFG_LEN + 4;  // idle after each frame
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        logic [15:0] nbytes;   // after the sfd, fcs included
        logic        corrupt;  // flip a payload bit once the fcs is built
        logic        er_mid;   // er on the middle byte, frame cut there
        logic        bad_sfd;
        logic        pre_er;   // er on the fourth preamble byte
    } case_t;

    case_t       cases [NUM_CASES];
    logic        gmii_rx_clk;
    logic        switch_rst_n;
    logic [7:0]  gmii_rx_data;
    logic        gmii_rx_dv;
    logic        gmii_rx_er;
    logic [7:0]  frame_data;
    logic        frame_valid, frame_sof, frame_eof, frame_error;
    frame_len_t  frame_length;
    stat_count_t rx_frame_count, crc_error_count, rx_error_count, preamble_error_count;

    logic [7:0]  frame_buf [0:2047];  // bytes after the sfd
    logic [31:0] lcg_state;
    logic [31:0] case_id, exp_count, exp_sum;
    frame_len_t  exp_len;
    logic        exp_err, expect_frame;
    logic [31:0] frames_seen, chk_pass, chk_fail;
    int          tb_pass, tb_fail;
    int          exp_frames, exp_errors, exp_crc, exp_pre;  // counter totals
    int          cycle_count, cycle_limit;

    eth_rx_mac u_dut (
        .gmii_rx_clk(gmii_rx_clk), .switch_rst_n(switch_rst_n),
        .gmii_rx_data(gmii_rx_data), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
        .frame_data(frame_data), .frame_valid(frame_valid), .frame_sof(frame_sof),
        .frame_eof(frame_eof), .frame_error(frame_error), .frame_length(frame_length),
        .rx_frame_count(rx_frame_count), .crc_error_count(crc_error_count),
        .rx_error_count(rx_error_count), .preamble_error_count(preamble_error_count)
    );

    rx_frame_checker u_checker (
        .gmii_rx_clk(gmii_rx_clk), .switch_rst_n(switch_rst_n),
        .frame_data(frame_data), .frame_valid(frame_valid), .frame_sof(frame_sof),
        .frame_eof(frame_eof), .frame_error(frame_error), .frame_length(frame_length),
        .case_id(case_id), .expect_frame(expect_frame), .exp_count(exp_count),
        .exp_sum(exp_sum), .exp_len(exp_len), .exp_err(exp_err),
        .frames_seen(frames_seen), .pass_count(chk_pass), .fail_count(chk_fail)
    );

    // ====================
    // clock and timeout
    // ====================
    initial begin
        gmii_rx_clk = 1'b0;
        forever #5 gmii_rx_clk = ~gmii_rx_clk;
    end

    always @(posedge gmii_rx_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // reflected crc-32, bit serial, lsb of the byte first
    function automatic logic [31:0] fold_crc_byte(input logic [31:0] crc_in,
                                                  input logic [7:0] d);
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ `ETH_CRC_POLY;
            end
        end
        return c;
    endfunction

    function automatic int counter_differs(input string name, input int exp,
                                           input stat_count_t act);
        if (act !== stat_count_t'(exp)) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            return 1;
        end
        return 0;
    endfunction

    // ====================
    // case table
    // ====================
    task automatic load_cases();
        cases[0] = '{16'd64,   1'b0, 1'b0, 1'b0, 1'b0};  // minimum good frame
        cases[1] = '{16'd100,  1'b0, 1'b0, 1'b0, 1'b0};
        cases[2] = '{16'd1518, 1'b0, 1'b0, 1'b0, 1'b0};  // maximum good frame
        cases[3] = '{16'd100,  1'b1, 1'b0, 1'b0, 1'b0};  // bad fcs
        cases[4] = '{16'd40,   1'b0, 1'b0, 1'b0, 1'b0};  // runt, fcs valid
        cases[5] = '{16'd1530, 1'b0, 1'b0, 1'b0, 1'b0};  // oversize, cut at max + 1
        cases[6] = '{16'd100,  1'b0, 1'b1, 1'b0, 1'b0};  // er mid frame
        cases[7] = '{16'd64,   1'b0, 1'b0, 1'b1, 1'b0};  // bad sfd, dropped
        cases[8] = '{16'd64,   1'b0, 1'b0, 1'b0, 1'b1};  // er in preamble
        cases[9] = '{16'd64,   1'b0, 1'b0, 1'b0, 1'b0};  // recovery
    endtask

    task automatic drive_gmii(input logic [7:0] d, input logic dv, input logic er);
        @(negedge gmii_rx_clk);
        gmii_rx_data = d;
        gmii_rx_dv   = dv;
        gmii_rx_er   = er;
    endtask

    // random payload, then the inverted crc lsb first
    task automatic build_frame(input int n, input logic corrupt);
        logic [31:0] crc;
        crc = `ETH_CRC_INIT;
        for (int i = 0; i < n - 4; i++) begin
            lcg_state    = lcg_next(lcg_state);
            frame_buf[i] = lcg_state[23:16];
            crc          = fold_crc_byte(crc, frame_buf[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame_buf[n - 4 + i] = crc[8*i +: 8];
        end
        if (corrupt) begin
            frame_buf[n / 2] = frame_buf[n / 2] ^ 8'h01;  // well past the header
        end
    endtask

    task automatic set_expected(input case_t c);
        int   acc;  // bytes the mac should accept
        logic crc_bad;
        acc = c.nbytes;
        if (c.er_mid) begin
            acc = c.nbytes / 2;
        end else if (c.nbytes > `ETH_MAX_FRAME) begin
            acc = `ETH_MAX_FRAME + 1;
        end
        crc_bad      = c.corrupt || (acc != c.nbytes);  // cut frame misses its fcs
        expect_frame = !c.bad_sfd && !c.pre_er;
        exp_count    = acc;
        exp_len      = frame_len_t'(acc);
        exp_err      = crc_bad || c.er_mid || (acc < `ETH_MIN_FRAME) ||
                       (c.nbytes > `ETH_MAX_FRAME);
        exp_sum      = '0;
        for (int i = 0; i < acc; i++) begin
            exp_sum = exp_sum + {24'h0, frame_buf[i]};
        end
        if (expect_frame) begin
            exp_frames += 1;
            exp_errors += int'(exp_err);
            exp_crc    += int'(crc_bad);
        end
        exp_pre += int'(c.pre_er);
    endtask

    task automatic send_frame(input case_t c);
        for (int i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
            drive_gmii(`ETH_PREAMBLE_BYTE, 1'b1, c.pre_er && (i == 3));
        end
        drive_gmii(c.bad_sfd ? 8'hD4 : `ETH_SFD_BYTE, 1'b1, 1'b0);
        for (int i = 0; i < int'(c.nbytes); i++) begin
            if (c.er_mid && i == c.nbytes / 2) begin
                drive_gmii(frame_buf[i], 1'b1, 1'b1);  // carrier drops right after
                break;
            end
            drive_gmii(frame_buf[i], 1'b1, 1'b0);
        end
        repeat (GAP_CYCLES) drive_gmii(8'h00, 1'b0, 1'b0);
    endtask

    task automatic check_counters();
        int bad;
        bad = 0;
        bad += counter_differs("rx_frame_count", exp_frames, rx_frame_count);
        bad += counter_differs("rx_error_count", exp_errors, rx_error_count);
        bad += counter_differs("crc_error_count", exp_crc, crc_error_count);
        bad += counter_differs("preamble_error_count", exp_pre, preamble_error_count);
        $display("counters: %s, frames %0d errors %0d crc %0d preamble %0d",
                 (bad == 0) ? "pass" : "fail", rx_frame_count, rx_error_count,
                 crc_error_count, preamble_error_count);
        if (bad == 0) begin
            tb_pass++;
        end else begin
            tb_fail++;
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int seen_before;
        gmii_rx_data = 8'h00;
        gmii_rx_dv   = 1'b0;
        gmii_rx_er   = 1'b0;
        switch_rst_n = 1'b0;
        lcg_state    = 32'h1fcc3c70;
        case_id      = '0;
        expect_frame = 1'b0;
        exp_count    = '0;
        exp_sum      = '0;
        exp_len      = '0;
        exp_err      = 1'b0;
        tb_pass      = 0;
        tb_fail      = 0;
        exp_frames   = 0;
        exp_errors   = 0;
        exp_crc      = 0;
        exp_pre      = 0;
        cycle_count  = 0;
        load_cases();
        cycle_limit = RESET_CYCLES;
        for (int k = 0; k < NUM_CASES; k++) begin
            cycle_limit += `ETH_PREAMBLE_LEN + 1 + cases[k].nbytes + GAP_CYCLES + 20;
        end

        repeat (RESET_CYCLES) @(negedge gmii_rx_clk);
        switch_rst_n = 1'b1;

        for (int k = 0; k < NUM_CASES; k++) begin
            case_id = k;
            build_frame(cases[k].nbytes, cases[k].corrupt);
            set_expected(cases[k]);
            seen_before = frames_seen;
            send_frame(cases[k]);
            if (expect_frame && frames_seen != seen_before + 1) begin
                $display("case %0d: no frame_eof came out for a frame that should pass", k);
                tb_fail++;
            end else if (!expect_frame && frames_seen == seen_before) begin
                $display("case %0d: pass, no frame as expected", k);
                tb_pass++;
            end
        end

        check_counters();
        $display("tests passed %0d failed %0d", chk_pass + tb_pass, chk_fail + tb_fail);
        if (chk_fail + tb_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
